// ==== fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// byte address width seen by the IFU and the cache
`define FB_ADDR_BITS 32

// one cache line, four instruction words
`define FB_LINE_BITS 128

// queue entries beyond the line in flight
`define FB_DEPTH 4

// queue pointer width, top bit is the wrap bit
`define FB_PTR_BITS 3

// first fetch address after reset
`define FB_RESET_PC 32'h8000_0000

`endif

// ==== fetch_pkg.sv ====
`default_nettype none

`include "fetch_config.svh"

package fetch_pkg;

  // request channel state
  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    RESP
  } fetch_state_e;

  // line number, pc without the byte offset inside a line
  typedef logic [`FB_ADDR_BITS-5:0] line_tag_t;

  typedef logic [`FB_LINE_BITS-1:0] line_t;

  typedef logic [31:0] inst_t;

  // one queue slot, line data plus its error flag
  typedef struct packed {
    line_t line;
    logic  fault;
  } q_entry_t;

endpackage

`default_nettype wire

// ==== line_queue_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

interface line_queue_if;

  // controller side requests
  logic                 push;
  logic                 pop;
  logic                 flush;
  fetch_pkg::q_entry_t  push_entry;

  // queue side status
  logic                 full;
  logic                 empty;
  logic [`FB_PTR_BITS-1:0] count;
  fetch_pkg::q_entry_t  head_entry;

  modport ctrl (
    output push, pop, flush, push_entry,
    input  full, empty, count, head_entry
  );

  modport queue (
    input  push, pop, flush, push_entry,
    output full, empty, count, head_entry
  );

endinterface

`default_nettype wire

// ==== line_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module line_store (
  input  wire                          clk,
  input  wire                          wen_i,
  input  wire [`FB_PTR_BITS-2:0]       waddr_i,
  input  wire fetch_pkg::q_entry_t     wentry_i,
  input  wire [`FB_PTR_BITS-2:0]       raddr_i,
  output fetch_pkg::q_entry_t          rentry_o
);

  fetch_pkg::q_entry_t mem [`FB_DEPTH];

  always_ff @(posedge clk) begin
    if (wen_i) begin
      mem[waddr_i] <= wentry_i;
    end
  end

  // write data shows through on a read of the same slot
  always_comb begin
    if (wen_i && (waddr_i == raddr_i)) begin
      rentry_o = wentry_i;
    end else begin
      rentry_o = mem[raddr_i];
    end
  end

endmodule

`default_nettype wire

// ==== line_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module line_queue (
  input  wire         clk,
  input  wire         rst_n,
  line_queue_if.queue q
);

  logic [`FB_PTR_BITS-1:0] wptr_q;
  logic [`FB_PTR_BITS-1:0] rptr_q;
  logic                    wen;

  // a flush wins over push and pop
  assign wen = q.push && !q.flush;

  // ==================================================
  // pointers
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      wptr_q <= '0;
    end else if (wen) begin
      wptr_q <= wptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      rptr_q <= '0;
    end else if (q.flush) begin
      // drop everything queued
      rptr_q <= wptr_q;
    end else if (q.pop) begin
      rptr_q <= rptr_q + 1'b1;
    end
  end

  // same slot, opposite lap means full
  assign q.full  = (rptr_q == {~wptr_q[`FB_PTR_BITS-1], wptr_q[`FB_PTR_BITS-2:0]});
  assign q.empty = (rptr_q == wptr_q);
  assign q.count = wptr_q - rptr_q;

  // storage
  line_store u_store (
    .clk      (clk),
    .wen_i    (wen),
    .waddr_i  (wptr_q[`FB_PTR_BITS-2:0]),
    .wentry_i (q.push_entry),
    .raddr_i  (rptr_q[`FB_PTR_BITS-2:0]),
    .rentry_o (q.head_entry)
  );

endmodule

`default_nettype wire

// ==== fetch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     flush_i,
  input  wire                     ar_ready_i,
  input  wire                     r_valid_i,
  input  wire fetch_pkg::line_t   r_data_i,
  input  wire [1:0]               r_resp_i,
  input  wire fetch_pkg::line_tag_t pc_line_i,
  input  wire fetch_pkg::line_tag_t head_line_i,
  output logic                    ar_valid_o,
  output logic                    r_ready_o,
  output logic                    discard_o,
  output logic                    pop_o,
  line_queue_if.ctrl              q
);

  fetch_pkg::fetch_state_e state_q;
  fetch_pkg::fetch_state_e state_d;
  fetch_pkg::line_tag_t    next_line;
  logic                    discard_q;
  logic                    r_fire;
  logic                    pop;

  // ==================================================
  // request state machine
  // ==================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::IDLE: begin
        if (!q.full && !flush_i) begin
          state_d = fetch_pkg::ADDR;
        end
      end
      fetch_pkg::ADDR: begin
        if (ar_ready_i) begin
          state_d = fetch_pkg::RESP;
        end
      end
      fetch_pkg::RESP: begin
        if (r_valid_i) begin
          state_d = fetch_pkg::IDLE;
        end
      end
      default: state_d = fetch_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= fetch_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign ar_valid_o = (state_q == fetch_pkg::ADDR);
  assign r_ready_o  = (state_q == fetch_pkg::RESP);
  assign r_fire     = r_valid_i & r_ready_o;

  // ==================================================
  // discard of the response that was in flight at a jump
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      discard_q <= 1'b0;
    end else if (r_fire) begin
      discard_q <= 1'b0;
    end else if (flush_i && state_q != fetch_pkg::IDLE) begin
      discard_q <= 1'b1;
    end
  end

  assign discard_o = discard_q;

  // queue requests
  assign next_line = head_line_i + 1'b1;
  assign pop       = !q.empty && !flush_i && (pc_line_i == next_line);
  assign pop_o     = pop;

  assign q.pop              = pop;
  assign q.flush            = flush_i;
  assign q.push             = r_fire && !discard_q && !flush_i;
  assign q.push_entry.line  = r_data_i;
  assign q.push_entry.fault = |r_resp_i;

endmodule

`default_nettype wire

// ==== pc_window.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module pc_window (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          flush_i,
  input  wire [`FB_ADDR_BITS-1:0]      pc_i,
  input  wire                          pop_i,
  input  wire [`FB_PTR_BITS-1:0]       count_i,
  input  wire                          enter_addr_i,
  output fetch_pkg::line_tag_t         pc_line_o,
  output fetch_pkg::line_tag_t         head_line_o,
  output logic [`FB_ADDR_BITS-1:0]     ar_addr_o
);

  localparam logic [`FB_ADDR_BITS-1:0] RESET_PC = `FB_RESET_PC;

  fetch_pkg::line_tag_t head_q;
  fetch_pkg::line_tag_t req_line;

  assign pc_line_o = pc_i[`FB_ADDR_BITS-1:4];

  // ==================================================
  // head line, the line at the front of the queue
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      head_q <= RESET_PC[`FB_ADDR_BITS-1:4];
    end else if (flush_i) begin
      head_q <= pc_i[`FB_ADDR_BITS-1:4];
    end else if (pop_i) begin
      head_q <= head_q + 1'b1;
    end
  end

  assign head_line_o = head_q;

  // next line to fetch sits right after the queued ones
  assign req_line = head_q + fetch_pkg::line_tag_t'(count_i);

  // held while the request is out
  always_ff @(posedge clk) begin
    if (enter_addr_i) begin
      ar_addr_o <= {req_line, 4'b0000};
    end
  end

endmodule

`default_nettype wire

// ==== word_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module word_select (
  input  wire [`FB_ADDR_BITS-1:0]      pc_i,
  input  wire fetch_pkg::line_tag_t    head_line_i,
  input  wire                          empty_i,
  input  wire fetch_pkg::q_entry_t     head_entry_i,
  input  wire                          r_fire_i,
  input  wire fetch_pkg::line_t        r_data_i,
  input  wire [1:0]                    r_resp_i,
  input  wire                          discard_i,
  output logic                         inst_valid_o,
  output fetch_pkg::inst_t             inst_o,
  output logic                         inst_fault_o
);

  logic             on_head;
  fetch_pkg::line_t src_line;
  logic             src_fault;

  assign on_head = (pc_i[`FB_ADDR_BITS-1:4] == head_line_i);

  // hit in the queue, or the head line arriving right now
  assign inst_valid_o = on_head && (!empty_i || (r_fire_i && !discard_i));

  // an empty queue means the word comes off the bus
  assign src_line  = empty_i ? r_data_i : head_entry_i.line;
  assign src_fault = empty_i ? (|r_resp_i) : head_entry_i.fault;

  assign inst_o       = inst_valid_o ? src_line[pc_i[3:2]*32 +: 32] : '0;
  assign inst_fault_o = inst_valid_o & src_fault;

endmodule

`default_nettype wire

// ==== fetch_buffer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module fetch_buffer_top (
  input  wire                        clk,
  input  wire                        rst_n,
  // cache read channel
  output logic                       ar_valid_o,
  input  wire                        ar_ready_i,
  output logic [`FB_ADDR_BITS-1:0]   ar_addr_o,
  input  wire                        r_valid_i,
  output logic                       r_ready_o,
  input  wire [`FB_LINE_BITS-1:0]    r_data_i,
  input  wire [1:0]                  r_resp_i,
  // IFU side
  input  wire [`FB_ADDR_BITS-1:0]    pc_i,
  input  wire                        flush_i,
  output logic                       inst_valid_o,
  output logic [31:0]                inst_o,
  output logic                       inst_fault_o
);

  fetch_pkg::line_tag_t pc_line;
  fetch_pkg::line_tag_t head_line;
  logic                 discard;
  logic                 pop;
  logic                 r_fire;
  logic                 in_idle;

  line_queue_if q_if ();

  assign r_fire  = r_valid_i & r_ready_o;
  // no request out, address register follows head + count
  assign in_idle = ~(ar_valid_o | r_ready_o);

  fetch_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .ar_ready_i  (ar_ready_i),
    .r_valid_i   (r_valid_i),
    .r_data_i    (r_data_i),
    .r_resp_i    (r_resp_i),
    .pc_line_i   (pc_line),
    .head_line_i (head_line),
    .ar_valid_o  (ar_valid_o),
    .r_ready_o   (r_ready_o),
    .discard_o   (discard),
    .pop_o       (pop),
    .q           (q_if.ctrl)
  );

  line_queue u_queue (
    .clk   (clk),
    .rst_n (rst_n),
    .q     (q_if.queue)
  );

  pc_window u_window (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .pc_i         (pc_i),
    .pop_i        (pop),
    .count_i      (q_if.count),
    .enter_addr_i (in_idle),
    .pc_line_o    (pc_line),
    .head_line_o  (head_line),
    .ar_addr_o    (ar_addr_o)
  );

  word_select u_select (
    .pc_i         (pc_i),
    .head_line_i  (head_line),
    .empty_i      (q_if.empty),
    .head_entry_i (q_if.head_entry),
    .r_fire_i     (r_fire),
    .r_data_i     (r_data_i),
    .r_resp_i     (r_resp_i),
    .discard_i    (discard),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o),
    .inst_fault_o (inst_fault_o)
  );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD_NS = 10;
  localparam int RESET_CYCLES   = 10;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end
  end

  // reset is active high, held for the first cycles
  initial begin
    rst_n_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb_fetch_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module tb_fetch_buffer;

  localparam int NUM_STEPS       = 3000;
  localparam int CYCLES_PER_STEP = 40;
  localparam int CLK_PERIOD_NS   = 20;
  localparam int WATCHDOG_NS     = NUM_STEPS * CYCLES_PER_STEP * CLK_PERIOD_NS;
  localparam logic [`FB_ADDR_BITS-1:0] RESET_PC = `FB_RESET_PC;

  logic clk;
  logic rst_n;

  // DUT inputs
  logic                     ar_ready = 1'b0;
  logic                     r_valid  = 1'b0;
  logic [`FB_LINE_BITS-1:0] r_data   = '0;
  logic [1:0]               r_resp   = 2'b00;
  logic [`FB_ADDR_BITS-1:0] pc       = `FB_RESET_PC;
  logic                     flush    = 1'b0;

  // DUT outputs
  logic                     ar_valid;
  logic [`FB_ADDR_BITS-1:0] ar_addr;
  logic                     r_ready;
  logic                     inst_valid;
  logic [31:0]              inst;
  logic                     inst_fault;

  // model state
  integer                   seed = 32'h872f_f0f4;
  int                       step_cnt = 0;
  int                       stall_cnt = 0;
  int                       ar_cnt = 0;
  int                       r_cnt = 0;
  logic                     started = 1'b0;
  logic                     resp_pending = 1'b0;
  logic                     stale = 1'b0;
  logic                     ar_fire;
  logic                     r_fire;
  logic [`FB_ADDR_BITS-5:0] resp_line = '0;
  logic [`FB_ADDR_BITS-5:0] exp_line = RESET_PC[`FB_ADDR_BITS-1:4];
  logic                     prev_ar_valid = 1'b0;
  logic                     prev_ar_ready = 1'b0;
  logic [`FB_ADDR_BITS-1:0] prev_ar_addr = '0;

  int err_data = 0;
  int err_order = 0;
  int err_limit = 0;
  int err_proto = 0;
  int err_reset = 0;

  tb_clock_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  fetch_buffer_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .ar_valid_o   (ar_valid),
    .ar_ready_i   (ar_ready),
    .ar_addr_o    (ar_addr),
    .r_valid_i    (r_valid),
    .r_ready_o    (r_ready),
    .r_data_i     (r_data),
    .r_resp_i     (r_resp),
    .pc_i         (pc),
    .flush_i      (flush),
    .inst_valid_o (inst_valid),
    .inst_o       (inst),
    .inst_fault_o (inst_fault)
  );

  // ==================================================
  // memory contents and random helpers
  // ==================================================
  function automatic logic [31:0] mix_hash(input logic [`FB_ADDR_BITS-5:0] line,
                                           input logic [2:0] idx);
    logic [31:0] h;
    h = {line, 1'b0, idx} * 32'h9e37_79b1;
    h = h ^ (h >> 15);
    h = h * 32'h2c1b_3c6d;
    h = h ^ (h >> 13);
    return h;
  endfunction

  // word w of a line sits at bits 32*w and up
  function automatic logic [`FB_LINE_BITS-1:0] line_data(input logic [`FB_ADDR_BITS-5:0] line);
    logic [`FB_LINE_BITS-1:0] d;
    for (int w = 0; w < 4; w++) begin
      d[w*32 +: 32] = mix_hash(line, 3'(w));
    end
    return d;
  endfunction

  // nonzero code marks a bus error on that line
  function automatic logic [1:0] resp_code(input logic [`FB_ADDR_BITS-5:0] line);
    logic [31:0] h;
    h = mix_hash(line, 3'd4);
    return h[0] ? {1'b1, h[1]} : 2'b00;
  endfunction

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    int unsigned r;
    r = rand_word();
    return r % n;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("ERR %s expected %h actual %h", name, exp, act);
  endtask

  // ==================================================
  // checks
  // ==================================================
  task automatic check_reset_state();
    if ({ar_valid, r_ready, inst_valid} != 3'b000) begin
      err_reset++;
      report_mismatch("reset_outputs", 32'h0, {29'h0, ar_valid, r_ready, inst_valid});
    end
  endtask

  task automatic check_handshake();
    if (prev_ar_valid && !prev_ar_ready) begin
      if (!ar_valid) begin
        err_proto++;
        $display("protocol: ar_valid_o dropped before ar_ready_i was seen");
      end
      if (ar_addr != prev_ar_addr) begin
        err_proto++;
        report_mismatch("ar_addr_hold", prev_ar_addr, ar_addr);
      end
    end
    if (ar_valid && resp_pending) begin
      err_proto++;
      $display("protocol: new request while a response is still outstanding");
    end
    if (r_ready && !resp_pending) begin
      err_proto++;
      $display("protocol: r_ready_o high with no accepted address");
    end
    prev_ar_valid = ar_valid;
    prev_ar_ready = ar_ready;
    prev_ar_addr  = ar_addr;
  endtask

  task automatic check_word();
    logic [31:0] exp_word;
    logic        exp_fault;
    exp_word  = mix_hash(pc[`FB_ADDR_BITS-1:4], {1'b0, pc[3:2]});
    exp_fault = |resp_code(pc[`FB_ADDR_BITS-1:4]);
    if (inst_valid) begin
      if (inst != exp_word) begin
        err_data++;
        report_mismatch("inst_word", exp_word, inst);
      end
      if (inst_fault != exp_fault) begin
        err_data++;
        report_mismatch("inst_fault", {31'h0, exp_fault}, {31'h0, inst_fault});
      end
    end else if (inst != 32'h0) begin
      err_data++;
      report_mismatch("inst_idle", 32'h0, inst);
    end
  endtask

  task automatic track_requests();
    logic [`FB_ADDR_BITS-5:0] ahead;
    ahead = ar_addr[`FB_ADDR_BITS-1:4] - pc[`FB_ADDR_BITS-1:4];
    // a request from before a jump is answered and then dropped
    if (ar_fire && !stale && !flush) begin
      if (ar_addr != {exp_line, 4'h0}) begin
        err_order++;
        report_mismatch("prefetch_addr", {exp_line, 4'h0}, ar_addr);
      end
      if (ahead >= `FB_DEPTH) begin
        err_limit++;
        $display("limit: line %h requested while the IFU is at line %h",
                 ar_addr[`FB_ADDR_BITS-1:4], pc[`FB_ADDR_BITS-1:4]);
      end
      exp_line = exp_line + 1'b1;
    end
    if (r_fire) begin
      stale = 1'b0;
    end else if (flush && (ar_valid || r_ready)) begin
      stale = 1'b1;
    end
    if (flush) begin
      exp_line = pc[`FB_ADDR_BITS-1:4];
    end
  endtask

  // ==================================================
  // cache and IFU models
  // ==================================================
  task automatic drive_cache();
    if (ar_fire) begin
      ar_ready     <= 1'b0;
      resp_line    = ar_addr[`FB_ADDR_BITS-1:4];
      resp_pending = 1'b1;
      r_cnt        = rand_below(5);
      ar_cnt       = rand_below(4);
    end else if (ar_valid && !ar_ready) begin
      if (ar_cnt == 0) begin
        ar_ready <= 1'b1;
      end else begin
        ar_cnt--;
      end
    end
    if (r_fire) begin
      r_valid      <= 1'b0;
      r_data       <= {4{rand_word()}};
      r_resp       <= 2'b00;
      resp_pending = 1'b0;
    end else if (resp_pending && !r_valid) begin
      if (r_cnt == 0) begin
        r_valid <= 1'b1;
        r_data  <= line_data(resp_line);
        r_resp  <= resp_code(resp_line);
      end else begin
        r_cnt--;
      end
    end
  endtask

  task automatic drive_ifu();
    if (flush) begin
      flush <= 1'b0;
    end else if (stall_cnt != 0) begin
      stall_cnt--;
    end else if (inst_valid) begin
      step_cnt++;
      if (rand_below(12) == 0) begin
        flush <= 1'b1;
        pc    <= RESET_PC + (rand_word() & 32'h0000_03fc);
      end else if (rand_below(16) == 0) begin
        // core busy for a while so the queue fills up
        stall_cnt = rand_below(64);
      end else if (rand_below(4) != 0) begin
        pc <= pc + 32'd4;
      end
    end
  endtask

  // outputs sampled here are the settled values of the cycle that ends
  always @(posedge clk) begin
    if (!rst_n) begin
      ar_fire = ar_valid && ar_ready;
      r_fire  = r_valid && r_ready;
      if (!started) begin
        check_reset_state();
        started = 1'b1;
      end
      check_handshake();
      check_word();
      track_requests();
      drive_cache();
      drive_ifu();
    end
  end

  initial begin
    wait (step_cnt >= NUM_STEPS);
    repeat (4) @(posedge clk);
    $display("steps=%0d errors data=%0d order=%0d limit=%0d protocol=%0d reset=%0d",
             step_cnt, err_data, err_order, err_limit, err_proto, err_reset);
    if (err_data + err_order + err_limit + err_proto + err_reset == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns with %0d of %0d steps done",
             WATCHDOG_NS, step_cnt, NUM_STEPS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
fetch_pkg.sv
line_queue_if.sv
line_store.sv
line_queue.sv
fetch_ctrl.sv
pc_window.sv
word_select.sv
fetch_buffer_top.sv
tb_clock_gen.sv
tb_fetch_buffer.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       := tb_fetch_buffer
FILELIST  := list.f

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(filter %.sv %.v,$(shell cat $(FILELIST))) $(wildcard *.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
